//--- hdl/dot_pkg.sv
package dot_pkg;

    // matrix geometry, rows and columns alike
    localparam int ROWS = 8;

    // clocks per displayed row, small for simulation
    // (on the board this gives the 1 kHz row rate)
    localparam int SCAN_DIV = 4;

    localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_DIV - 1);

    // row lines are active low
    localparam logic [ROWS-1:0] ROW_OFF = '1;

    typedef logic [$clog2(ROWS)-1:0] row_idx_t;

    typedef struct packed {
        logic [3:0] scene;  // picture code, 12..15 blank
        logic       fail;   // game lost
    } scene_cmd_t;

endpackage

//--- hdl/glyph_rom.sv
`timescale 1ns/10ps

module glyph_rom
(
    input  dot_pkg::scene_cmd_t        sel,
    input  dot_pkg::row_idx_t          row_idx,
    output logic [dot_pkg::ROWS-1:0]   green,
    output logic [dot_pkg::ROWS-1:0]   red
);

    logic [dot_pkg::ROWS-1:0] g_pic;
    logic [dot_pkg::ROWS-1:0] r_pic;
    logic                     copy_g;

    // green pictures, stage levels and the like
    always_comb
    begin
        g_pic = '0;
        case (sel.scene)
            4'd0:
                case (row_idx)
                    3'd2, 3'd5: g_pic = 8'b0001_1000;
                    3'd3, 3'd4: g_pic = 8'b0011_1100;
                    default:    g_pic = 8'b0000_0000;
                endcase
            4'd1:
                case (row_idx)
                    3'd2, 3'd5: g_pic = 8'b0011_1000;
                    3'd3, 3'd4: g_pic = 8'b0111_1100;
                    default:    g_pic = 8'b0000_0000;
                endcase
            4'd2:
                case (row_idx)
                    3'd2, 3'd5: g_pic = 8'b0011_1100;
                    3'd3, 3'd4: g_pic = 8'b0111_1110;
                    default:    g_pic = 8'b0000_0000;
                endcase
            4'd3:
                case (row_idx)
                    3'd1, 3'd6:             g_pic = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: g_pic = 8'b0111_1110;
                    default:                g_pic = 8'b0000_0000;
                endcase
            4'd4:
                case (row_idx)
                    3'd0, 3'd7: g_pic = 8'b0011_1100;
                    3'd1, 3'd6: g_pic = 8'b0111_1110;
                    default:    g_pic = 8'b1111_1111;
                endcase
            4'd5: g_pic = 8'b1111_1111;  // full square
            4'd6:
                case (row_idx)
                    3'd0: g_pic = 8'b1100_0011;
                    3'd1: g_pic = 8'b1110_0011;
                    3'd2: g_pic = 8'b1111_0001;
                    3'd3: g_pic = 8'b1110_0011;
                    3'd4: g_pic = 8'b1100_0111;
                    3'd5: g_pic = 8'b1110_0111;
                    3'd6: g_pic = 8'b1111_0111;
                    default: g_pic = 8'b1111_1011;
                endcase
            4'd7:
                case (row_idx)
                    3'd1: g_pic = 8'b0000_0001;
                    3'd2: g_pic = 8'b1000_0001;
                    3'd3: g_pic = 8'b1100_0011;
                    3'd4: g_pic = 8'b1000_0011;
                    3'd5: g_pic = 8'b1100_0111;
                    3'd6: g_pic = 8'b1110_0111;
                    3'd7: g_pic = 8'b1111_0011;
                    default: g_pic = 8'b0000_0000;
                endcase
            4'd9:
                case (row_idx)
                    3'd2: g_pic = 8'b0110_0000;
                    3'd3: g_pic = 8'b1111_1100;
                    3'd4: g_pic = 8'b0011_1111;
                    3'd5: g_pic = 8'b0011_1110;
                    3'd6: g_pic = 8'b0001_1100;
                    default: g_pic = 8'b0000_0000;
                endcase
            4'd10:
                case (row_idx)
                    3'd2:       g_pic = 8'b0001_1000;
                    3'd3:       g_pic = 8'b0011_1100;
                    3'd4, 3'd5: g_pic = 8'b0111_1110;
                    3'd6:       g_pic = 8'b0010_0100;
                    default:    g_pic = 8'b0000_0000;
                endcase
            default: g_pic = '0;
        endcase
    end

    // red-only pictures, 8 is the win face and 11 the fail mark
    always_comb
    begin
        r_pic = '0;
        case (sel.scene)
            4'd8:
                case (row_idx)
                    3'd1: r_pic = 8'b0011_1000;
                    3'd2: r_pic = 8'b0100_0100;
                    3'd3: r_pic = 8'b0101_1010;
                    3'd4: r_pic = 8'b0100_1010;
                    3'd5: r_pic = 8'b0011_0010;
                    3'd6: r_pic = 8'b1100_0100;
                    3'd7: r_pic = 8'b0011_1000;
                    default: r_pic = 8'b0000_0000;
                endcase
            4'd11:
                case (row_idx)
                    3'd0: r_pic = 8'b1110_0000;
                    3'd1: r_pic = 8'b0110_0000;
                    3'd2: r_pic = 8'b1110_0000;
                    3'd3: r_pic = 8'b0011_0000;
                    3'd4: r_pic = 8'b0011_0001;
                    3'd5: r_pic = 8'b0011_0011;
                    3'd6: r_pic = 8'b0011_1110;
                    default: r_pic = 8'b0001_1100;
                endcase
            default: r_pic = '0;
        endcase
    end

    // which scenes mirror green into red, making them yellow
    always_comb
    begin
        if (sel.fail)
            copy_g = (sel.scene == 4'd6) || (sel.scene == 4'd7) || (sel.scene == 4'd9);
        else
            copy_g = (sel.scene <= 4'd7) || (sel.scene == 4'd9);
    end

    assign green = g_pic;
    assign red   = r_pic | (copy_g ? g_pic : '0);  // r_pic and g_pic never overlap

endmodule

//--- hdl/matrix_scan.sv
`timescale 1ns/10ps

module matrix_scan
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       st,
    input  dot_pkg::scene_cmd_t        cur,
    output logic [dot_pkg::ROWS-1:0]   row,
    output logic [dot_pkg::ROWS-1:0]   colg,
    output logic [dot_pkg::ROWS-1:0]   colr
);

    logic [dot_pkg::SCAN_W-1:0] presc;
    dot_pkg::row_idx_t          row_cnt;
    logic [dot_pkg::ROWS-1:0]   strobe;
    logic [dot_pkg::ROWS-1:0]   green;
    logic [dot_pkg::ROWS-1:0]   red;

    glyph_rom glyph_rom_inst
    (
        .sel     (cur),
        .row_idx (row_cnt),
        .green   (green),
        .red     (red)
    );

    // row prescaler and counter, held at zero while blanked
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            presc   <= '0;
            row_cnt <= '0;
        end
        else if (!st)
        begin
            presc   <= '0;
            row_cnt <= '0;
        end
        else if (presc == dot_pkg::SCAN_LAST)
        begin
            presc   <= '0;
            row_cnt <= row_cnt + 1'b1;  // wraps 7 -> 0
        end
        else
        begin
            presc <= presc + 1'b1;
        end
    end

    // one low bit for the active row
    always_comb
    begin
        strobe          = dot_pkg::ROW_OFF;
        strobe[row_cnt] = 1'b0;
    end

    // strobe and columns taken from the same count on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= dot_pkg::ROW_OFF;
            colg <= '0;
            colr <= '0;
        end
        else if (!st)
        begin
            row  <= dot_pkg::ROW_OFF;
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= strobe;
            colg <= green;
            colr <= red;
        end
    end

endmodule

//--- hdl/scene_latch.sv
`timescale 1ns/10ps

module scene_latch
(
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_req,
    input  dot_pkg::scene_cmd_t cmd,
    output logic                cmd_ack,
    output dot_pkg::scene_cmd_t cur
);

    typedef enum logic
    {
        IDLE  = 1'b0,
        ACKED = 1'b1
    } state_t;

    state_t state;

    // four-phase receiver
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (cmd_req)
                        state <= ACKED;
                end
                ACKED:
                begin
                    if (!cmd_req)
                        state <= IDLE;  // host released, ready for next
                end
                default: state <= IDLE;
            endcase
        end
    end

    // capture only on the idle -> acked edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cur <= '0;
        else if (state == IDLE && cmd_req)
            cur <= cmd;
    end

    assign cmd_ack = (state == ACKED);

endmodule

//--- hdl/dot_display_top.sv
`timescale 1ns/10ps

module dot_display_top
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       st,
    input  logic                       cmd_req,
    input  dot_pkg::scene_cmd_t        cmd,
    output logic                       cmd_ack,
    output logic [dot_pkg::ROWS-1:0]   row,
    output logic [dot_pkg::ROWS-1:0]   colg,
    output logic [dot_pkg::ROWS-1:0]   colr
);

    dot_pkg::scene_cmd_t cur;  // scene on display

    scene_latch scene_latch_inst
    (
        .clk     (clk),
        .rst     (rst),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .cur     (cur)
    );

    matrix_scan matrix_scan_inst
    (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .cur  (cur),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

endmodule

//--- tests/dot_display_tb.sv
`timescale 1ns/10ps

module dot_display_tb;

    logic                       clk;
    logic                       rst;
    logic                       st;
    logic                       cmd_req;
    dot_pkg::scene_cmd_t        cmd;
    logic                       cmd_ack;
    logic [dot_pkg::ROWS-1:0]   row;
    logic [dot_pkg::ROWS-1:0]   colg;
    logic [dot_pkg::ROWS-1:0]   colr;

    // one entry per stimulus line with row 0 in the low byte
    logic                                     st_q[$];
    dot_pkg::scene_cmd_t                      cmd_q[$];
    logic [dot_pkg::ROWS*dot_pkg::ROWS-1:0]   exp_g_q[$];
    logic [dot_pkg::ROWS*dot_pkg::ROWS-1:0]   exp_r_q[$];

    int          checks;
    int          errors;
    int          cycles;
    int          cycle_limit;
    logic [15:0] lfsr;
    logic        req_seen;
    logic        hs_on;

    dot_display_top dot_display_top_inst
    (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .row     (row),
        .colg    (colg),
        .colr    (colr)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: simulation did not finish");
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // cmd_req as the DUT saw it on the last rising edge
    always @(posedge clk or posedge rst)
    begin
        if (rst)
            req_seen <= 1'b0;
        else
            req_seen <= cmd_req;
    end

    // ack follows req by one cycle in both phases
    always @(negedge clk)
    begin
        if (hs_on)
        begin
            checks = checks + 1;
            assert (cmd_ack === req_seen)
            else
            begin
                $display("error at %0t: cmd_ack %b but cmd_req was %b one cycle before",
                         $time, cmd_ack, req_seen);
                errors = errors + 1;
            end
        end
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic rand_gap(output int gap);
        int i;
        begin
            gap = 0;
            for (i = 0; i < 3; i++)
            begin
                lfsr = lfsr_step(lfsr);
                gap = (gap << 1) | lfsr[0];
            end
        end
    endtask

    function automatic logic [7:0] count_low(input logic [dot_pkg::ROWS-1:0] r);
        logic [7:0] n;
        n = 0;
        for (int i = 0; i < dot_pkg::ROWS; i++)
            if (r[i] === 1'b0)
                n = n + 1;
        return n;
    endfunction

    function automatic logic [7:0] low_index(input logic [dot_pkg::ROWS-1:0] r);
        logic [7:0] idx;
        idx = 8'hff;  // none found
        for (int i = dot_pkg::ROWS - 1; i >= 0; i--)
            if (r[i] === 1'b0)
                idx = i;
        return idx;
    endfunction

    task automatic check_eq(input string what, input int scene, input int ridx,
                            input logic [7:0] exp_v, input logic [7:0] act_v);
        begin
            checks = checks + 1;
            assert (act_v === exp_v)
            else
            begin
                $display("error at %0t: %s scene %0d row %0d expected %h got %h",
                         $time, what, scene, ridx, exp_v, act_v);
                errors = errors + 1;
            end
        end
    endtask

    task automatic read_stimulus();
        int                                     fd;
        int                                     n;
        int                                     st_v;
        int                                     sc_v;
        int                                     fl_v;
        string                                  line;
        logic [7:0]                             g[8];
        logic [7:0]                             r[8];
        dot_pkg::scene_cmd_t                    c;
        logic [dot_pkg::ROWS*dot_pkg::ROWS-1:0] gp;
        logic [dot_pkg::ROWS*dot_pkg::ROWS-1:0] rp;
        begin
            fd = $fopen("tests/dot_stimulus.txt", "r");
            if (fd == 0)
            begin
                $display("could not open the stimulus file tests/dot_stimulus.txt");
                errors = errors + 1;
            end
            else
            begin
                while (!$feof(fd))
                begin
                    line = "";
                    n = $fgets(line, fd);
                    if (line.len() == 0 || line.getc(0) == "#")
                        continue;
                    n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        st_v, sc_v, fl_v, g[0], g[1], g[2], g[3], g[4], g[5], g[6], g[7],
                        r[0], r[1], r[2], r[3], r[4], r[5], r[6], r[7]);
                    if (n == 19)
                    begin
                        c.scene = sc_v[3:0];
                        c.fail  = fl_v[0];
                        for (int i = 0; i < dot_pkg::ROWS; i++)
                        begin
                            gp[8*i +: 8] = g[i];
                            rp[8*i +: 8] = r[i];
                        end
                        st_q.push_back(st_v[0]);
                        cmd_q.push_back(c);
                        exp_g_q.push_back(gp);
                        exp_r_q.push_back(rp);
                    end
                    else if (n > 0)
                    begin
                        $display("stimulus line could not be read: %s", line);
                        errors = errors + 1;
                    end
                end
                $fclose(fd);
            end
        end
    endtask

    // four-phase host side with junk on cmd while ack is high
    task automatic send_cmd(input dot_pkg::scene_cmd_t c);
        int gap;
        begin
            cmd = c;
            rand_gap(gap);
            repeat (gap) @(negedge clk);
            cmd_req = 1'b1;
            do
                @(negedge clk);
            while (!cmd_ack);
            cmd = ~c;
            rand_gap(gap);
            repeat (gap) @(negedge clk);
            cmd_req = 1'b0;
            do
                @(negedge clk);
            while (cmd_ack);
        end
    endtask

    // one sample per row change for eight rows
    task automatic check_frame(input int e);
        logic [dot_pkg::ROWS-1:0]               last_row;
        logic [dot_pkg::ROWS*dot_pkg::ROWS-1:0] eg;
        logic [dot_pkg::ROWS*dot_pkg::ROWS-1:0] er;
        int                                     prev_idx;
        int                                     exp_idx;
        int                                     got;
        int                                     scene;
        begin
            eg    = exp_g_q[e];
            er    = exp_r_q[e];
            scene = cmd_q[e].scene;
            last_row = row;
            if (row === dot_pkg::ROW_OFF)
                prev_idx = dot_pkg::ROWS - 1;  // next row must be 0 after blanking
            else
                prev_idx = low_index(row);
            got = 0;
            while (got < dot_pkg::ROWS)
            begin
                @(negedge clk);
                if (row !== last_row)
                begin
                    last_row = row;
                    exp_idx  = (prev_idx + 1) % dot_pkg::ROWS;
                    check_eq("low row lines", scene, exp_idx, 8'd1, count_low(row));
                    check_eq("row index", scene, exp_idx, exp_idx, low_index(row));
                    check_eq("colg", scene, exp_idx, eg[8*exp_idx +: 8], colg);
                    check_eq("colr", scene, exp_idx, er[8*exp_idx +: 8], colr);
                    prev_idx = exp_idx;
                    got = got + 1;
                end
            end
        end
    endtask

    task automatic check_blank(input int e);
        logic [dot_pkg::ROWS*dot_pkg::ROWS-1:0] eg;
        logic [dot_pkg::ROWS*dot_pkg::ROWS-1:0] er;
        int                                     k;
        begin
            eg = exp_g_q[e];
            er = exp_r_q[e];
            @(negedge clk);  // first edge with st low
            for (int i = 0; i < dot_pkg::ROWS * dot_pkg::SCAN_DIV; i++)
            begin
                @(negedge clk);
                k = i % dot_pkg::ROWS;
                check_eq("row blank", cmd_q[e].scene, k, dot_pkg::ROW_OFF, row);
                check_eq("colg blank", cmd_q[e].scene, k, eg[8*k +: 8], colg);
                check_eq("colr blank", cmd_q[e].scene, k, er[8*k +: 8], colr);
            end
        end
    endtask

    task automatic run_entry(input int e);
        logic was_on;
        begin
            send_cmd(cmd_q[e]);
            was_on = st;
            st = st_q[e];
            if (!st_q[e])
                check_blank(e);
            else if (!was_on)
                check_frame(e);  // st just rose
            else
            begin
                repeat (dot_pkg::ROWS * dot_pkg::SCAN_DIV) @(negedge clk);
                check_frame(e);
            end
        end
    endtask

    initial
    begin
        int e;
        clk         = 1'b0;
        rst         = 1'b1;
        st          = 1'b1;
        cmd_req     = 1'b0;
        cmd         = '0;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 1000;
        lfsr        = 16'd27060;
        hs_on       = 1'b0;

        read_stimulus();
        cycle_limit = cmd_q.size() * (3 * dot_pkg::ROWS * dot_pkg::SCAN_DIV + 40) + 100;
        if (cmd_q.size() == 0)
        begin
            $display("no test entries in the stimulus file");
            errors = errors + 1;
        end

        repeat (3) @(negedge clk);
        rst = 1'b0;
        // no rising edge since release, so only the reset sets these
        check_eq("row after reset", 0, 0, dot_pkg::ROW_OFF, row);
        check_eq("colg after reset", 0, 0, 8'h00, colg);
        check_eq("colr after reset", 0, 0, 8'h00, colr);
        check_eq("cmd_ack after reset", 0, 0, 8'h00, {7'b0, cmd_ack});
        hs_on <= 1'b1;

        for (e = 0; e < cmd_q.size(); e++)
            run_entry(e);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tests/dot_stimulus.txt
# st scene fail, then green rows 0..7 and red rows 0..7, all hex
# st 0 lines expect a dark matrix
1 0 0 00 00 18 3c 3c 18 00 00 00 00 18 3c 3c 18 00 00
1 1 0 00 00 38 7c 7c 38 00 00 00 00 38 7c 7c 38 00 00
1 2 0 00 00 3c 7e 7e 3c 00 00 00 00 3c 7e 7e 3c 00 00
1 3 0 00 3c 7e 7e 7e 7e 3c 00 00 3c 7e 7e 7e 7e 3c 00
1 4 0 3c 7e ff ff ff ff 7e 3c 3c 7e ff ff ff ff 7e 3c
1 5 0 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
1 6 0 c3 e3 f1 e3 c7 e7 f7 fb c3 e3 f1 e3 c7 e7 f7 fb
1 7 0 00 01 81 c3 83 c7 e7 f3 00 01 81 c3 83 c7 e7 f3
1 8 0 00 00 00 00 00 00 00 00 00 38 44 5a 4a 32 c4 38
1 9 0 00 00 60 fc 3f 3e 1c 00 00 00 60 fc 3f 3e 1c 00
1 a 0 00 00 18 3c 7e 7e 24 00 00 00 00 00 00 00 00 00
1 b 0 00 00 00 00 00 00 00 00 e0 60 e0 30 31 33 3e 1c
1 c 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1 d 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1 e 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1 f 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1 0 1 00 00 18 3c 3c 18 00 00 00 00 00 00 00 00 00 00
1 5 1 ff ff ff ff ff ff ff ff 00 00 00 00 00 00 00 00
0 5 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1 6 1 c3 e3 f1 e3 c7 e7 f7 fb c3 e3 f1 e3 c7 e7 f7 fb
1 8 1 00 00 00 00 00 00 00 00 00 38 44 5a 4a 32 c4 38
1 9 1 00 00 60 fc 3f 3e 1c 00 00 00 60 fc 3f 3e 1c 00
1 b 1 00 00 00 00 00 00 00 00 e0 60 e0 30 31 33 3e 1c
0 3 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
0 a 1 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1 4 0 3c 7e ff ff ff ff 7e 3c 3c 7e ff ff ff ff 7e 3c
1 7 0 00 01 81 c3 83 c7 e7 f3 00 01 81 c3 83 c7 e7 f3

//--- list.f
hdl/dot_pkg.sv
hdl/glyph_rom.sv
hdl/matrix_scan.sv
hdl/scene_latch.sv
hdl/dot_display_top.sv
tests/dot_display_tb.sv
